// File: rtl/icache_pkg.sv
package icache_pkg;

        // cache geometry
        // one doubleword per line, direct mapped
        localparam int icache_index_w  = 10;
        localparam int icache_tag_w    = 19;
        localparam int icache_offset_w = 3;

        // derived sizes for the two arrays
        localparam int icache_lines = 1 << icache_index_w;
        localparam int icache_bytes = icache_lines << icache_offset_w;

        // controller state encodings
        localparam int icache_state_w = 3;
        localparam logic [icache_state_w-1:0] icache_st_idle        = 3'd0;
        localparam logic [icache_state_w-1:0] icache_st_lookup      = 3'd1;
        localparam logic [icache_state_w-1:0] icache_st_fill_setup  = 3'd2;
        localparam logic [icache_state_w-1:0] icache_st_fill_access = 3'd3;
        localparam logic [icache_state_w-1:0] icache_st_fill_update = 3'd4;
        localparam logic [icache_state_w-1:0] icache_st_reread      = 3'd5;

        // bus and fetch words
        typedef logic [31:0] icache_word_t;
        typedef logic [63:0] icache_dword_t;

        // lookup fields
        typedef logic [icache_index_w-1:0] icache_index_t;
        typedef logic [icache_tag_w-1:0]   icache_tag_t;

        // address split as the tag and data lookups see it
        typedef struct packed {
                icache_tag_t                tag;
                icache_index_t              index;
                logic [icache_offset_w-1:0] offset;
        } icache_addr_fields_t;

        // one 32-bit address, read either as a raw bus address
        // or as tag / index / offset for the arrays
        typedef union packed {
                icache_word_t        raw;
                icache_addr_fields_t f;
        } icache_addr_u;

endpackage

// File: rtl/icache_data_if.sv
`timescale 1ns/1ns

// controller to data RAM
interface icache_data_if
        import icache_pkg::*;
();

        // doubleword address into the byte array
        icache_index_t adr;
        // 32-bit write data, placed by we
        icache_word_t  di;
        // we[1] upper half (bytes 0..3), we[0] lower half (bytes 4..7)
        logic [1:0]    we;
        logic          enable;
        // registered read, holds while enable is low
        icache_dword_t do_data;

        modport ctrl (
                output adr, di, we, enable,
                input  do_data
        );

        modport ram (
                input  adr, di, we, enable,
                output do_data
        );

endinterface

// File: rtl/icache_tag_if.sv
`timescale 1ns/1ns

// controller to tag store
interface icache_tag_if
        import icache_pkg::*;
();

        // line being looked up or filled
        icache_index_t index;
        // tag stored on write
        icache_tag_t   wtag;
        // store wtag and set valid at index
        logic          write;
        // launch a registered lookup at index
        logic          rd_en;
        // clear every valid bit
        logic          flush;

        // lookup result, one cycle after rd_en
        icache_tag_t   rtag;
        logic          rvalid;

        modport ctrl (
                output index, wtag, write, rd_en, flush,
                input  rtag, rvalid
        );

        modport store (
                input  index, wtag, write, rd_en, flush,
                output rtag, rvalid
        );

endinterface

// File: rtl/icache_data_ram.sv
`timescale 1ns/1ns

module icache_data_ram
        import icache_pkg::*;
(
        input logic        clk,
        icache_data_if.ram port
);

        // byte array, byte 0 of a line is the most significant byte
        logic [7:0] mem [0:icache_bytes-1];

        // write path
        // each half is written byte by byte, big-endian within the half
        always_ff @(posedge clk) begin
                if (port.enable) begin
                        for (int b = 0; b < 4; b++) begin
                                // upper half sits at offsets 0..3
                                if (port.we[1]) begin
                                        mem[{port.adr, 1'b0, 2'(b)}] <= port.di[31 - 8*b -: 8];
                                end
                                // lower half sits at offsets 4..7
                                if (port.we[0]) begin
                                        mem[{port.adr, 1'b1, 2'(b)}] <= port.di[31 - 8*b -: 8];
                                end
                        end
                end
        end

        // read path
        // registered doubleword, old contents on a same-cycle write
        always_ff @(posedge clk) begin
                if (port.enable) begin
                        for (int b = 0; b < 8; b++) begin
                                port.do_data[63 - 8*b -: 8] <= mem[{port.adr, 3'(b)}];
                        end
                end
        end

endmodule

// File: rtl/icache_tag_ram.sv
`timescale 1ns/1ns

module icache_tag_ram
        import icache_pkg::*;
(
        input logic          clk,
        input logic          rst_n,
        icache_tag_if.store  port
);

        // tag array, contents only meaningful under valid
        icache_tag_t tag_mem [0:icache_lines-1];

        // one valid flop per line so a flush clears in a single cycle
        logic [icache_lines-1:0] valid_q;

        // valid bits
        // reset and flush both wipe the whole vector
        always_ff @(posedge clk) begin
                if (!rst_n || port.flush) begin
                        valid_q <= '0;
                end else if (port.write) begin
                        valid_q[port.index] <= 1'b1;
                end
        end

        // tag write on fill completion
        always_ff @(posedge clk) begin
                if (port.write) begin
                        tag_mem[port.index] <= port.wtag;
                end
        end

        // registered lookup
        // result stays put until the next rd_en
        always_ff @(posedge clk) begin
                if (port.rd_en) begin
                        port.rtag   <= tag_mem[port.index];
                        port.rvalid <= valid_q[port.index];
                end
        end

endmodule

// File: rtl/icache_ctrl.sv
`timescale 1ns/1ns

module icache_ctrl
        import icache_pkg::*;
(
        input  logic          clk,
        input  logic          rst_n,

        // fetch side
        input  logic          fetch_req,
        input  icache_addr_u  fetch_addr,
        output logic          fetch_ack,
        output icache_dword_t fetch_data,

        input  logic          flush,

        // apb requester, read only
        output icache_addr_u  paddr,
        output logic          psel,
        output logic          penable,
        input  icache_word_t  prdata,
        input  logic          pready,

        icache_data_if.ctrl   data,
        icache_tag_if.ctrl    tag
);

        logic [icache_state_w-1:0] state;

        // request captured at acceptance
        // every fill address and the new tag come from here
        icache_addr_u req_addr;

        // which bus word of the line is in flight
        // 0 is the upper half, 1 the lower half
        logic fill_word;

        logic is_idle;
        logic accept;
        logic hit;
        logic word_done;
        icache_index_t line_index;

        assign is_idle = (state == icache_st_idle);

        // flush wins over a request on the same edge
        // and a request still held during the ack cycle is not taken again
        assign accept = is_idle && fetch_req && !fetch_ack && !flush;

        // tag compare against the registered request
        assign hit = tag.rvalid && (tag.rtag == req_addr.f.tag);

        // access phase ends on the edge where pready is seen
        assign word_done = (state == icache_st_fill_access) && pready;

        // idle looks up the live address so the read launches on the accept edge
        assign line_index = is_idle ? fetch_addr.f.index : req_addr.f.index;

        // tag store
        assign tag.index = line_index;
        assign tag.wtag  = req_addr.f.tag;
        assign tag.rd_en = accept;
        assign tag.write = (state == icache_st_fill_update);
        // only honoured while idle
        assign tag.flush = is_idle && flush;

        // data RAM
        assign data.adr = line_index;
        assign data.di  = prdata;

        always_comb begin
                data.enable = 1'b0;
                data.we     = 2'b00;
                if (accept) begin
                        // hit path read
                        data.enable = 1'b1;
                end else if (word_done) begin
                        // write the arriving word straight into its half
                        data.enable = 1'b1;
                        data.we     = fill_word ? 2'b01 : 2'b10;
                end else if (state == icache_st_fill_update) begin
                        // reread the completed line
                        data.enable = 1'b1;
                end
        end

        // apb address
        // line address, plus 4 for the second word
        always_comb begin
                paddr          = req_addr;
                paddr.f.offset = {fill_word, 2'b00};
        end

        assign psel    = (state == icache_st_fill_setup) || (state == icache_st_fill_access);
        assign penable = (state == icache_st_fill_access);

        // control state
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        state     <= icache_st_idle;
                        fill_word <= 1'b0;
                        fetch_ack <= 1'b0;
                end else begin
                        // ack is a single-cycle pulse
                        fetch_ack <= 1'b0;
                        case (state)
                                icache_st_idle: begin
                                        if (accept) begin
                                                state <= icache_st_lookup;
                                        end
                                end
                                icache_st_lookup: begin
                                        if (hit) begin
                                                fetch_ack <= 1'b1;
                                                state     <= icache_st_idle;
                                        end else begin
                                                fill_word <= 1'b0;
                                                state     <= icache_st_fill_setup;
                                        end
                                end
                                icache_st_fill_setup: begin
                                        state <= icache_st_fill_access;
                                end
                                icache_st_fill_access: begin
                                        // pready low just stretches this state
                                        if (pready) begin
                                                if (fill_word) begin
                                                        state <= icache_st_fill_update;
                                                end else begin
                                                        fill_word <= 1'b1;
                                                        state     <= icache_st_fill_setup;
                                                end
                                        end
                                end
                                icache_st_fill_update: begin
                                        state <= icache_st_reread;
                                end
                                icache_st_reread: begin
                                        fetch_ack <= 1'b1;
                                        state     <= icache_st_idle;
                                end
                                default: begin
                                        state <= icache_st_idle;
                                end
                        endcase
                end
        end

        // payload registers
        always_ff @(posedge clk) begin
                if (accept) begin
                        req_addr <= fetch_addr;
                end
                // data RAM output is valid in lookup and reread
                if ((state == icache_st_lookup && hit) || state == icache_st_reread) begin
                        fetch_data <= data.do_data;
                end
        end

endmodule

// File: rtl/icache_top.sv
`timescale 1ns/1ns

module icache_top
        import icache_pkg::*;
(
        input  logic          clk,
        input  logic          rst_n,

        // processor fetch port
        input  logic          fetch_req,
        input  icache_addr_u  fetch_addr,
        output logic          fetch_ack,
        output icache_dword_t fetch_data,

        // clears every line
        input  logic          flush,

        // apb requester to backing memory
        output icache_addr_u  paddr,
        output logic          psel,
        output logic          penable,
        output logic          pwrite,
        input  icache_word_t  prdata,
        input  logic          pready
);

        // controller to arrays
        icache_data_if data_bus ();
        icache_tag_if  tag_bus ();

        // the cache never writes backing memory
        assign pwrite = 1'b0;

        icache_ctrl u_ctrl (
                .clk        (clk),
                .rst_n      (rst_n),
                .fetch_req  (fetch_req),
                .fetch_addr (fetch_addr),
                .fetch_ack  (fetch_ack),
                .fetch_data (fetch_data),
                .flush      (flush),
                .paddr      (paddr),
                .psel       (psel),
                .penable    (penable),
                .prdata     (prdata),
                .pready     (pready),
                .data       (data_bus.ctrl),
                .tag        (tag_bus.ctrl)
        );

        // 8 KB line data
        icache_data_ram u_data_ram (
                .clk  (clk),
                .port (data_bus.ram)
        );

        // tags and valid bits
        icache_tag_ram u_tag_ram (
                .clk   (clk),
                .rst_n (rst_n),
                .port  (tag_bus.store)
        );

endmodule

// File: verification/icache_apb_mem.sv
`timescale 1ns/1ns

// apb completer backing the cache, read only
module icache_apb_mem
        import icache_pkg::*;
#(
        parameter icache_word_t key       = 32'h0,
        parameter int           max_waits = 3
)(
        input  logic         clk,
        input  logic         rst_n,
        input  icache_addr_u paddr,
        input  logic         psel,
        input  logic         penable,
        input  logic         pwrite,
        output icache_word_t prdata,
        output logic         pready
);

        icache_word_t data_q     = '0;
        logic         ready_q    = 1'b0;
        logic         armed      = 1'b0;
        int           waits_left = 0;

        // read log for the testbench
        int           read_count = 0;
        icache_addr_u last_addr;
        icache_addr_u prev_addr;

        assign prdata = data_q;
        assign pready = ready_q;

        // pready and prdata change on the falling edge only
        always @(negedge clk) begin
                if (!rst_n || !psel || !penable) begin
                        ready_q = 1'b0;
                        armed   = 1'b0;
                end else begin
                        // new access phase, pick its wait states once
                        if (!armed) begin
                                waits_left = int'($urandom % (max_waits + 1));
                                armed      = 1'b1;
                        end
                        if (waits_left == 0) begin
                                ready_q = 1'b1;
                                // pattern word covers every address bit
                                data_q  = paddr.raw ^ key;
                        end else begin
                                waits_left--;
                        end
                end
        end

        // a read completes on the edge where pready is seen high
        // an access with pwrite high is not a read and is left out of the log
        always @(posedge clk) begin
                if (!rst_n) begin
                        read_count = 0;
                end else if (psel && penable && pready && !pwrite) begin
                        read_count++;
                        prev_addr = last_addr;
                        last_addr = paddr;
                end
        end

endmodule

// File: verification/icache_tb.sv
`timescale 1ns/1ns

module icache_tb
        import icache_pkg::*;
();

        localparam int           clk_half         = 4;
        localparam int           reset_cycles     = 8;
        localparam int unsigned  run_seed         = 32'h00ad_7e38;
        localparam icache_word_t mem_key          = 32'h5a3c_96e1;
        localparam int           max_waits        = 3;
        localparam int           directed_fetches = 5;
        localparam int           random_fetches   = 200;
        // request, lookup, two setup plus access phases, update, reread, ack hold and gap
        localparam int           worst_fetch      = 2 + 2 * (2 + max_waits) + 5;
        localparam int           timeout_cycles   = reset_cycles + 64
                + (directed_fetches + random_fetches) * worst_fetch;

        // same index 0x247, tags differ by one
        localparam icache_word_t addr_a = 32'h0000_1238;
        localparam icache_word_t addr_b = 32'h0000_3238;

        logic          clk = 1'b0;
        logic          rst_n;
        logic          fetch_req;
        icache_addr_u  fetch_addr;
        logic          fetch_ack;
        icache_dword_t fetch_data;
        logic          flush;
        icache_addr_u  paddr;
        logic          psel;
        logic          penable;
        logic          pwrite;
        icache_word_t  prdata;
        logic          pready;
        int            cycle_count = 0;

        // reference direct-mapped state for the random run
        bit            model_valid [0:icache_lines-1];
        icache_tag_t   model_tag   [0:icache_lines-1];

        always #clk_half clk = ~clk;

        icache_top DUT (
                .clk (clk), .rst_n (rst_n),
                .fetch_req (fetch_req), .fetch_addr (fetch_addr),
                .fetch_ack (fetch_ack), .fetch_data (fetch_data),
                .flush (flush),
                .paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite),
                .prdata (prdata), .pready (pready)
        );

        icache_apb_mem #(.key (mem_key), .max_waits (max_waits)) mem_model (
                .clk (clk), .rst_n (rst_n),
                .paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite),
                .prdata (prdata), .pready (pready)
        );

        task automatic abort_run(input string why);
                $display("%s", why);
                $display("Test failed");
                $fatal(1, "simulation stopped");
        endtask

        task automatic check_dword(input string name, input icache_dword_t exp, act);
                if (act !== exp)
                        abort_run($sformatf("FAILED at %0t ns: %s expected %h got %h",
                                            $time, name, exp, act));
        endtask

        task automatic check_addr(input string name, input icache_addr_u exp, act);
                if (act.raw !== exp.raw)
                        abort_run($sformatf("FAILED at %0t ns: %s expected %h got %h",
                                            $time, name, exp.raw, act.raw));
        endtask

        task automatic check_bit(input string name, input logic exp, act);
                if (act !== exp)
                        abort_run($sformatf("FAILED at %0t ns: %s expected %b got %b",
                                            $time, name, exp, act));
        endtask

        task automatic check_count(input string name, input int exp, act);
                if (act != exp)
                        abort_run($sformatf("FAILED at %0t ns: %s expected %0d got %0d",
                                            $time, name, exp, act));
        endtask

        // first bus word lands in the upper half
        function automatic icache_dword_t expected_line(input icache_word_t addr);
                icache_word_t base;
                base = {addr[31:3], 3'b000};
                return {base ^ mem_key, (base + 32'd4) ^ mem_key};
        endfunction

        // one fetch handshake, returns data, apb reads and cycles to ack
        task automatic do_fetch(input icache_word_t addr, output icache_dword_t d,
                                output int reads, output int cycles);
                int reads_before;
                @(negedge clk);
                fetch_req       = 1'b1;
                fetch_addr.raw  = addr;
                reads_before    = mem_model.read_count;
                cycles          = 0;
                do begin
                        @(negedge clk);
                        cycles++;
                end while (fetch_ack !== 1'b1);
                d     = fetch_data;
                reads = mem_model.read_count - reads_before;
                // request stays up over the edge that samples the ack
                @(negedge clk);
                fetch_req = 1'b0;
                // ack must be a single-cycle pulse
                check_bit("fetch_ack", 1'b0, fetch_ack);
                // the held request must not start a second lookup
                @(negedge clk);
                check_bit("fetch_ack", 1'b0, fetch_ack);
        endtask

        task automatic check_miss_fill(input icache_word_t addr, input icache_dword_t d,
                                       input int reads);
                icache_addr_u line;
                icache_addr_u second;
                line.raw   = {addr[31:3], 3'b000};
                second.raw = line.raw + 32'd4;
                check_count("apb read count", 2, reads);
                check_addr("paddr of first word", line, mem_model.prev_addr);
                check_addr("paddr of second word", second, mem_model.last_addr);
                check_dword("fetch_data", expected_line(addr), d);
        endtask

        task automatic pulse_flush();
                @(negedge clk);
                flush = 1'b1;
                @(negedge clk);
                flush = 1'b0;
        endtask

        task automatic reset_outputs_low();
                check_bit("fetch_ack", 1'b0, fetch_ack);
                check_bit("psel", 1'b0, psel);
                check_bit("penable", 1'b0, penable);
                check_bit("pwrite", 1'b0, pwrite);
        endtask

        task automatic cold_miss();
                icache_dword_t d;
                int reads;
                int cycles;
                do_fetch(addr_a, d, reads, cycles);
                check_miss_fill(addr_a, d, reads);
        endtask

        task automatic repeat_hit();
                icache_dword_t d;
                int reads;
                int cycles;
                do_fetch(addr_a, d, reads, cycles);
                check_count("apb read count", 0, reads);
                check_count("hit latency in cycles", 2, cycles);
                check_dword("fetch_data", expected_line(addr_a), d);
        endtask

        // b evicts a, then a evicts b
        task automatic conflict_refill();
                icache_dword_t d;
                int reads;
                int cycles;
                do_fetch(addr_b, d, reads, cycles);
                check_miss_fill(addr_b, d, reads);
                do_fetch(addr_a, d, reads, cycles);
                check_miss_fill(addr_a, d, reads);
        endtask

        task automatic flush_refill();
                icache_dword_t d;
                int reads;
                int cycles;
                pulse_flush();
                do_fetch(addr_a, d, reads, cycles);
                check_miss_fill(addr_a, d, reads);
        endtask

        // 4 tags over 16 lines so conflicts happen often
        task automatic random_run();
                icache_addr_u r;
                icache_dword_t d;
                int reads;
                int cycles;
                int misses;
                int total_reads;
                pulse_flush();
                for (int i = 0; i < icache_lines; i++)
                        model_valid[i] = 1'b0;
                misses      = 0;
                total_reads = 0;
                for (int n = 0; n < random_fetches; n++) begin
                        r.raw   = '0;
                        r.f.tag   = icache_tag_t'(32'h40 + ($urandom % 4));
                        r.f.index = icache_index_t'($urandom % 16);
                        if (!(model_valid[r.f.index] && model_tag[r.f.index] == r.f.tag)) begin
                                misses++;
                                model_valid[r.f.index] = 1'b1;
                                model_tag[r.f.index]   = r.f.tag;
                        end
                        do_fetch(r.raw, d, reads, cycles);
                        check_dword("fetch_data", expected_line(r.raw), d);
                        total_reads += reads;
                end
                check_count("apb read count over random run", 2 * misses, total_reads);
        endtask

        // run limit
        always @(posedge clk) begin
                cycle_count++;
                if (cycle_count > timeout_cycles)
                        abort_run($sformatf("timeout: tests still running after %0d cycles",
                                            timeout_cycles));
        end

        initial begin
                void'($urandom(run_seed));
                rst_n          = 1'b0;
                flush          = 1'b0;
                fetch_req      = 1'b0;
                fetch_addr.raw = '0;
                repeat (reset_cycles) @(negedge clk);
                rst_n = 1'b1;
                @(negedge clk);
                reset_outputs_low();
                cold_miss();
                repeat_hit();
                conflict_refill();
                flush_refill();
                random_run();
                $display("Test passed");
                $finish;
        end

endmodule

// File: sources.f
rtl/icache_pkg.sv
rtl/icache_data_if.sv
rtl/icache_tag_if.sv
rtl/icache_data_ram.sv
rtl/icache_tag_ram.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
verification/icache_apb_mem.sv
verification/icache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
